// ==== hw/nice_pkg.sv ====
//////////////////////////////////////////////////
// NICE coprocessor shared definitions
// Data widths, custom-3 opcodes, port structs
// and the operation FSM encoding
//////////////////////////////////////////////////
package nice_pkg;

  //////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////

  // Core data word
  localparam int XLEN = 32;
  typedef logic [XLEN-1:0] xlen_t;

  // Byte address on the memory bus
  typedef logic [31:0] addr_t;

  // Row buffer geometry
  localparam int ROWBUF_DP = 4;
  // Words moved by one instruction
  localparam int ROW_LEN = 3;
  typedef logic [$clog2(ROWBUF_DP)-1:0] buf_idx_t;

  // Address step and bus size code for one word
  localparam int WORD_BYTES = 4;
  localparam logic [1:0] ICB_SIZE_WORD = 2'd2;

  //////////////////////////////////////////////////
  // Instruction encodings, all R type
  //////////////////////////////////////////////////
  localparam logic [6:0] OPC_CUSTOM3 = 7'b1111011;

  localparam logic [2:0] F3_LBUF   = 3'b010;
  localparam logic [6:0] F7_LBUF   = 7'b0000001;
  localparam logic [2:0] F3_SBUF   = 3'b010;
  localparam logic [6:0] F7_SBUF   = 7'b0000010;
  localparam logic [2:0] F3_ROWSUM = 3'b110;
  localparam logic [6:0] F7_ROWSUM = 7'b0000110;

  // Operation FSM
  typedef enum logic [2:0] {
    IDLE,
    LBUF,
    SBUF,
    ROWSUM,
    RESP
  } nice_state_e;

  //////////////////////////////////////////////////
  // Port payloads
  //////////////////////////////////////////////////

  // Request from the core, rs2 not carried
  typedef struct packed {
    xlen_t inst;
    xlen_t rs1;
  } nice_req_t;

  // Response back to the core
  typedef struct packed {
    xlen_t rdat;
    logic  err;
  } nice_rsp_t;

  // Memory command
  typedef struct packed {
    addr_t      addr;
    logic       read;
    xlen_t      wdata;
    logic [1:0] size;
  } icb_cmd_t;

  // Memory response
  typedef struct packed {
    xlen_t rdata;
    logic  err;
  } icb_rsp_t;

  // One accepted memory response with its row slot
  typedef struct packed {
    xlen_t    data;
    buf_idx_t idx;
    logic     err;
  } mem_beat_t;

endpackage

// ==== hw/nice_ctrl.sv ====
//////////////////////////////////////////////////
// NICE control
// Decodes custom-3 requests, runs the operation
// FSM and holds the registered response
//////////////////////////////////////////////////
module nice_ctrl (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  logic                  req_valid,
  input  nice_pkg::nice_req_t   req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output nice_pkg::nice_rsp_t   rsp,
  input  logic                  rsp_ready,
  output nice_pkg::nice_state_e state,
  output logic                  start,
  output nice_pkg::addr_t       base_addr,
  output logic                  write_op,
  input  logic                  lsu_done,
  input  logic                  beat_valid,
  input  nice_pkg::mem_beat_t   beat,
  input  logic                  sum_done,
  input  nice_pkg::xlen_t       sum,
  output logic                  busy,
  output logic                  active
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  is_lbuf;
  logic                  is_sbuf;
  logic                  is_rowsum;
  logic                  is_mem;
  logic                  req_hs;
  logic                  rsp_hs;
  nice_pkg::nice_state_e state_next;
  nice_pkg::xlen_t       rdat_q;
  logic                  err_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  assign opcode = req.inst[6:0];
  assign funct3 = req.inst[14:12];
  assign funct7 = req.inst[31:25];

  assign is_lbuf   = (opcode == nice_pkg::OPC_CUSTOM3) && (funct3 == nice_pkg::F3_LBUF) &&
                     (funct7 == nice_pkg::F7_LBUF);
  assign is_sbuf   = (opcode == nice_pkg::OPC_CUSTOM3) && (funct3 == nice_pkg::F3_SBUF) &&
                     (funct7 == nice_pkg::F7_SBUF);
  assign is_rowsum = (opcode == nice_pkg::OPC_CUSTOM3) && (funct3 == nice_pkg::F3_ROWSUM) &&
                     (funct7 == nice_pkg::F7_ROWSUM);
  // Every supported op touches memory
  assign is_mem    = is_lbuf | is_sbuf | is_rowsum;

  // Only one request in flight
  assign req_ready = (state == nice_pkg::IDLE);
  assign req_hs    = req_valid & req_ready;
  assign rsp_valid = (state == nice_pkg::RESP);
  assign rsp_hs    = rsp_valid & rsp_ready;

  //////////////////////////////////////////////////
  // Operation FSM
  //////////////////////////////////////////////////
  always_comb
  begin
    state_next = state;
    case (state)
      nice_pkg::IDLE:
      begin
        if (req_hs)
        begin
          if (is_lbuf)
            state_next = nice_pkg::LBUF;
          else if (is_sbuf)
            state_next = nice_pkg::SBUF;
          else if (is_rowsum)
            state_next = nice_pkg::ROWSUM;
          else
            // Unsupported, answer right away with err
            state_next = nice_pkg::RESP;
        end
      end
      nice_pkg::LBUF, nice_pkg::SBUF:
      begin
        if (lsu_done)
          state_next = nice_pkg::RESP;
      end
      nice_pkg::ROWSUM:
      begin
        if (sum_done)
          state_next = nice_pkg::RESP;
      end
      nice_pkg::RESP:
      begin
        if (rsp_hs)
          state_next = nice_pkg::IDLE;
      end
      default: state_next = nice_pkg::IDLE;
    endcase
  end

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      state    <= nice_pkg::IDLE;
      start    <= 1'b0;
      write_op <= 1'b0;
      err_q    <= 1'b0;
    end
    else
    begin
      state <= state_next;
      // One-cycle kick to the LSU
      start <= req_hs & is_mem;
      if (req_hs)
        write_op <= is_sbuf;
      // Sticky error, seeded by the illegal check
      if (req_hs)
        err_q <= ~is_mem;
      else if (beat_valid && beat.err)
        err_q <= 1'b1;
    end
  end

  // Base address and result data
  always_ff @(posedge nice_clk)
  begin
    if (req_hs)
    begin
      base_addr <= req.rs1;
      rdat_q    <= '0;
    end
    else if (sum_done)
      rdat_q <= sum;
  end

  assign rsp.rdat = rdat_q;
  assign rsp.err  = err_q;

  // Core-side status
  assign busy   = (state != nice_pkg::IDLE);
  assign active = (state == nice_pkg::IDLE) ? req_valid : 1'b1;

  // Payload holds while the core stalls the response
  a_rsp_stable: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

// ==== hw/nice_lsu.sv ====
//////////////////////////////////////////////////
// NICE memory access unit
// Issues one row of word commands, counts the
// responses and forwards them as tagged beats
//////////////////////////////////////////////////
module nice_lsu (
  input  logic                nice_clk,
  input  logic                nice_rst_n,
  input  logic                start,
  input  nice_pkg::addr_t     base_addr,
  input  logic                write_op,
  output logic                icb_cmd_valid,
  input  logic                icb_cmd_ready,
  output nice_pkg::icb_cmd_t  icb_cmd,
  input  logic                icb_rsp_valid,
  output logic                icb_rsp_ready,
  input  nice_pkg::icb_rsp_t  icb_rsp,
  output nice_pkg::buf_idx_t  rd_idx,
  input  nice_pkg::xlen_t     rd_data,
  output logic                beat_valid,
  output nice_pkg::mem_beat_t beat,
  output logic                done
);

  logic            running;
  logic [2:0]      cmd_cnt;
  logic [2:0]      rsp_cnt;
  nice_pkg::addr_t addr_q;
  nice_pkg::addr_t cur_addr;
  logic            cmd_hs;
  logic            rsp_hs;

  //////////////////////////////////////////////////
  // Command side
  //////////////////////////////////////////////////

  // First command goes out in the start cycle
  assign cur_addr      = start ? base_addr : addr_q;
  // Separate counters, so commands run ahead of responses
  assign icb_cmd_valid = (start | running) && (cmd_cnt < 3'(nice_pkg::ROW_LEN));
  assign cmd_hs        = icb_cmd_valid & icb_cmd_ready;

  // Store data picked by the command index
  assign rd_idx = nice_pkg::buf_idx_t'(cmd_cnt);

  assign icb_cmd.addr  = cur_addr;
  assign icb_cmd.read  = ~write_op;
  assign icb_cmd.wdata = write_op ? rd_data : '0;
  assign icb_cmd.size  = nice_pkg::ICB_SIZE_WORD;

  // Address only steps on an accepted command
  always_ff @(posedge nice_clk)
  begin
    if (cmd_hs)
      addr_q <= cur_addr + nice_pkg::addr_t'(nice_pkg::WORD_BYTES);
    else if (start)
      addr_q <= base_addr;
  end

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // The core never pushes back on memory
  assign icb_rsp_ready = 1'b1;
  assign rsp_hs        = icb_rsp_valid & icb_rsp_ready;
  assign done          = rsp_hs && (rsp_cnt == 3'(nice_pkg::ROW_LEN - 1));

  // In-order responses, row slot = response count
  assign beat_valid = rsp_hs;
  assign beat.data  = icb_rsp.rdata;
  assign beat.idx   = nice_pkg::buf_idx_t'(rsp_cnt);
  assign beat.err   = icb_rsp.err;

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      running <= 1'b0;
      cmd_cnt <= '0;
      rsp_cnt <= '0;
    end
    else
    begin
      if (start)
        running <= 1'b1;
      else if (done)
        running <= 1'b0;
      // Both counters clear once the row is complete
      if (done)
        cmd_cnt <= '0;
      else if (cmd_hs)
        cmd_cnt <= cmd_cnt + 3'd1;
      if (done)
        rsp_cnt <= '0;
      else if (rsp_hs)
        rsp_cnt <= rsp_cnt + 3'd1;
    end
  end

  // Memory answers only what was asked
  a_rsp_outstanding: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    icb_rsp_valid |-> (rsp_cnt < cmd_cnt));

  // Never more than one row of commands
  a_cmd_bound: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    cmd_cnt <= 3'(nice_pkg::ROW_LEN));

endmodule

// ==== hw/nice_row_buf.sv ====
//////////////////////////////////////////////////
// NICE row buffer
// Four words, loaded by lbuf, accumulated by
// rowsum and read out for sbuf
//////////////////////////////////////////////////
module nice_row_buf (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  nice_pkg::nice_state_e state,
  input  logic                  beat_valid,
  input  nice_pkg::mem_beat_t   beat,
  input  logic                  acc_valid,
  input  nice_pkg::buf_idx_t    acc_idx,
  input  nice_pkg::xlen_t       acc_data,
  input  nice_pkg::buf_idx_t    rd_idx,
  output nice_pkg::xlen_t       rd_data
);

  nice_pkg::xlen_t entry_q [nice_pkg::ROWBUF_DP];
  logic            load_en;

  // Beats only land here during lbuf
  assign load_en = beat_valid && (state == nice_pkg::LBUF);

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      for (int i = 0; i < nice_pkg::ROWBUF_DP; i++)
        entry_q[i] <= '0;
    end
    else
    begin
      // Load from memory
      if (load_en)
        entry_q[beat.idx] <= beat.data;
      // Read-modify-write for rowsum
      if (acc_valid)
        entry_q[acc_idx] <= entry_q[acc_idx] + acc_data;
    end
  end

  // Store path, combinational
  assign rd_data = entry_q[rd_idx];

  // Load and accumulate belong to different ops
  a_no_write_clash: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    !(load_en && acc_valid));

endmodule

// ==== hw/nice_rowsum_unit.sv ====
//////////////////////////////////////////////////
// NICE rowsum datapath
// Registers each rowsum beat, keeps the running
// sum and feeds the row buffer accumulate port
//////////////////////////////////////////////////
module nice_rowsum_unit (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  nice_pkg::nice_state_e state,
  input  logic                  beat_valid,
  input  nice_pkg::mem_beat_t   beat,
  output logic                  acc_valid,
  output nice_pkg::buf_idx_t    acc_idx,
  output nice_pkg::xlen_t       acc_data,
  output nice_pkg::xlen_t       sum,
  output logic                  sum_done
);

  logic               rcv_vld;
  nice_pkg::xlen_t    rcv_q;
  nice_pkg::buf_idx_t rcv_idx;
  nice_pkg::xlen_t    sum_q;
  logic               take;

  // Only rowsum beats are summed
  assign take = beat_valid && (state == nice_pkg::ROWSUM);

  //////////////////////////////////////////////////
  // Receive register
  //////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      rcv_vld <= 1'b0;
    else
      rcv_vld <= take;
  end

  // Operands come from flops, not the bus
  always_ff @(posedge nice_clk)
  begin
    if (take)
    begin
      rcv_q   <= beat.data;
      rcv_idx <= beat.idx;
    end
  end

  //////////////////////////////////////////////////
  // Running sum
  //////////////////////////////////////////////////

  // First word restarts the sum, wraps at 32 bits
  assign sum = (rcv_idx == '0) ? rcv_q : sum_q + rcv_q;

  always_ff @(posedge nice_clk)
  begin
    if (rcv_vld)
      sum_q <= sum;
  end

  // Final word is in the receive register
  assign sum_done = rcv_vld && (rcv_idx == nice_pkg::buf_idx_t'(nice_pkg::ROW_LEN - 1));

  // Same word goes into the matching buffer slot
  assign acc_valid = rcv_vld;
  assign acc_idx   = rcv_idx;
  assign acc_data  = rcv_q;

endmodule

// ==== hw/nice_core_top.sv ====
//////////////////////////////////////////////////
// NICE coprocessor top
// Control, LSU, row buffer and rowsum datapath
//////////////////////////////////////////////////
module nice_core_top (
  input  logic                nice_clk,
  input  logic                nice_rst_n,
  // Request from the core
  input  logic                req_valid,
  output logic                req_ready,
  input  nice_pkg::nice_req_t req,
  // Response to the core
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output nice_pkg::nice_rsp_t rsp,
  // Memory command
  output logic                icb_cmd_valid,
  input  logic                icb_cmd_ready,
  output nice_pkg::icb_cmd_t  icb_cmd,
  // Memory response
  input  logic                icb_rsp_valid,
  output logic                icb_rsp_ready,
  input  nice_pkg::icb_rsp_t  icb_rsp,
  // Status
  output logic                busy,
  output logic                active
);

  nice_pkg::nice_state_e state;
  logic                  start;
  nice_pkg::addr_t       base_addr;
  logic                  write_op;
  logic                  lsu_done;
  logic                  beat_valid;
  nice_pkg::mem_beat_t   beat;
  logic                  sum_done;
  nice_pkg::xlen_t       sum;
  nice_pkg::buf_idx_t    rd_idx;
  nice_pkg::xlen_t       rd_data;
  logic                  acc_valid;
  nice_pkg::buf_idx_t    acc_idx;
  nice_pkg::xlen_t       acc_data;

  nice_ctrl u_ctrl (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_ready  (rsp_ready),
    .state      (state),
    .start      (start),
    .base_addr  (base_addr),
    .write_op   (write_op),
    .lsu_done   (lsu_done),
    .beat_valid (beat_valid),
    .beat       (beat),
    .sum_done   (sum_done),
    .sum        (sum),
    .busy       (busy),
    .active     (active)
  );

  nice_lsu u_lsu (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .start         (start),
    .base_addr     (base_addr),
    .write_op      (write_op),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp       (icb_rsp),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .beat_valid    (beat_valid),
    .beat          (beat),
    .done          (lsu_done)
  );

  nice_row_buf u_row_buf (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .state      (state),
    .beat_valid (beat_valid),
    .beat       (beat),
    .acc_valid  (acc_valid),
    .acc_idx    (acc_idx),
    .acc_data   (acc_data),
    .rd_idx     (rd_idx),
    .rd_data    (rd_data)
  );

  nice_rowsum_unit u_rowsum (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .state      (state),
    .beat_valid (beat_valid),
    .beat       (beat),
    .acc_valid  (acc_valid),
    .acc_idx    (acc_idx),
    .acc_data   (acc_data),
    .sum        (sum),
    .sum_done   (sum_done)
  );

endmodule

// ==== tests/tb_clk_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock and reset
// 40-unit clock, reset low for five cycles
//////////////////////////////////////////////////
module tb_clk_gen (
  output logic nice_clk,
  output logic nice_rst_n
);

  initial
  begin
    nice_clk = 1'b0;
    forever #20 nice_clk = ~nice_clk;
  end

  initial
  begin
    nice_rst_n = 1'b0;
    repeat (5) @(posedge nice_clk);
    nice_rst_n <= 1'b1;
  end

endmodule

// ==== tests/tb_mem_model.sv ====
//////////////////////////////////////////////////
// Bus memory model
// Word store with random stalls, random response
// gaps, in-order answers and an error region
//////////////////////////////////////////////////
module tb_mem_model (
  input  logic               nice_clk,
  input  logic               nice_rst_n,
  input  logic               icb_cmd_valid,
  output logic               icb_cmd_ready,
  input  nice_pkg::icb_cmd_t icb_cmd,
  output logic               icb_rsp_valid,
  input  logic               icb_rsp_ready,
  output nice_pkg::icb_rsp_t icb_rsp
);

  localparam nice_pkg::addr_t ERR_BASE = 32'h0000_f000;

  nice_pkg::xlen_t    mem [nice_pkg::addr_t];
  nice_pkg::icb_rsp_t pend_q [$];
  logic [31:0]        lfsr;
  int                 gap;

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Fill for untouched words from every address bit
  function automatic nice_pkg::xlen_t fill_word(input nice_pkg::addr_t a);
    return a ^ (a << 7) ^ 32'h6d2b_79f5;
  endfunction

  // Bus outputs start idle
  initial
  begin
    icb_cmd_ready = 1'b0;
    icb_rsp_valid = 1'b0;
    icb_rsp       = '0;
  end

  always @(posedge nice_clk or negedge nice_rst_n)
  begin : bus
    nice_pkg::icb_rsp_t r;
    if (!nice_rst_n)
    begin
      icb_cmd_ready <= 1'b0;
      icb_rsp_valid <= 1'b0;
      icb_rsp       <= '0;
      pend_q.delete();
      gap  = 0;
      lfsr = 32'h0a48f528;
    end
    else
    begin
      // Accept a command and fix its data at acceptance
      if (icb_cmd_valid && icb_cmd_ready)
      begin
        r.err = (icb_cmd.addr >= ERR_BASE);
        r.rdata = '0;
        if (!r.err && icb_cmd.read)
          r.rdata = mem.exists(icb_cmd.addr) ? mem[icb_cmd.addr] : fill_word(icb_cmd.addr);
        else if (!r.err)
          mem[icb_cmd.addr] = icb_cmd.wdata;
        pend_q.push_back(r);
      end
      icb_cmd_ready <= (rand_bits(2) != 0);

      // Present the oldest answer after a random gap
      if (icb_rsp_valid && icb_rsp_ready)
        icb_rsp_valid <= 1'b0;
      if ((!icb_rsp_valid || icb_rsp_ready) && (pend_q.size() > 0))
      begin
        if (gap == 0)
        begin
          icb_rsp       <= pend_q.pop_front();
          icb_rsp_valid <= 1'b1;
          gap = int'(rand_bits(2));
        end
        else
          gap = gap - 1;
      end
    end
  end

endmodule

// ==== tests/tb_nice_core.sv ====
//////////////////////////////////////////////////
// NICE coprocessor testbench
// Drives custom-3 requests, models the expected
// result and checks responses and bus commands
//////////////////////////////////////////////////
module tb_nice_core;

  localparam int TIMEOUT = 200;
  localparam nice_pkg::addr_t ERR_BASE = 32'h0000_f000;

  logic                nice_clk;
  logic                nice_rst_n;
  logic                req_valid;
  logic                req_ready;
  nice_pkg::nice_req_t req;
  logic                rsp_valid;
  logic                rsp_ready;
  nice_pkg::nice_rsp_t rsp;
  logic                icb_cmd_valid;
  logic                icb_cmd_ready;
  nice_pkg::icb_cmd_t  icb_cmd;
  logic                icb_rsp_valid;
  logic                icb_rsp_ready;
  nice_pkg::icb_rsp_t  icb_rsp;
  logic                busy;
  logic                active;

  // Shadow state
  nice_pkg::xlen_t     shadow_mem [nice_pkg::addr_t];
  nice_pkg::xlen_t     shadow_buf [nice_pkg::ROWBUF_DP];
  nice_pkg::xlen_t     exp_wdata [nice_pkg::ROW_LEN];
  int                  exp_ncmd;
  logic                exp_read;
  nice_pkg::nice_rsp_t exp_q [$];
  nice_pkg::icb_cmd_t  cmd_log [$];
  logic [31:0]         lfsr;
  int                  errors;
  int                  checks;
  bit                  abort;
  bit                  stall;

  tb_clk_gen clk0 (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n)
  );

  tb_mem_model mem0 (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp       (icb_rsp)
  );

  nice_core_top dut0 (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req           (req),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp),
    .icb_cmd_valid (icb_cmd_valid),
    .icb_cmd_ready (icb_cmd_ready),
    .icb_cmd       (icb_cmd),
    .icb_rsp_valid (icb_rsp_valid),
    .icb_rsp_ready (icb_rsp_ready),
    .icb_rsp       (icb_rsp),
    .busy          (busy),
    .active        (active)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic nice_pkg::xlen_t make_inst(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [6:0] opc);
    return {f7, 5'd0, 5'd10, f3, 5'd11, opc};
  endfunction

  // Memory word as the core should see it
  // The error region reads as zero
  function automatic nice_pkg::xlen_t word_at(input nice_pkg::addr_t a);
    if (a >= ERR_BASE)
      return '0;
    if (shadow_mem.exists(a))
      return shadow_mem[a];
    return a ^ (a << 7) ^ 32'h6d2b_79f5;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic nice_pkg::nice_rsp_t ref_op(input nice_pkg::xlen_t inst,
                                                 input nice_pkg::addr_t rs1);
    nice_pkg::nice_rsp_t r;
    nice_pkg::addr_t     a;
    nice_pkg::xlen_t     w;
    logic [6:0]          opc;
    logic [2:0]          f3;
    logic [6:0]          f7;
    opc = inst[6:0];
    f3 = inst[14:12];
    f7 = inst[31:25];
    r.rdat = '0;
    r.err = 1'b0;
    exp_ncmd = 3;
    exp_read = 1'b1;
    for (int i = 0; i < nice_pkg::ROW_LEN; i++)
    begin
      a = rs1 + nice_pkg::addr_t'(4 * i);
      w = word_at(a);
      if (opc != nice_pkg::OPC_CUSTOM3)
        exp_ncmd = 0;
      else if (f3 == nice_pkg::F3_LBUF && f7 == nice_pkg::F7_LBUF)
        shadow_buf[i] = w;
      else if (f3 == nice_pkg::F3_SBUF && f7 == nice_pkg::F7_SBUF)
      begin
        exp_read = 1'b0;
        exp_wdata[i] = shadow_buf[i];
        if (a < ERR_BASE)
          shadow_mem[a] = shadow_buf[i];
      end
      else if (f3 == nice_pkg::F3_ROWSUM && f7 == nice_pkg::F7_ROWSUM)
      begin
        r.rdat = r.rdat + w;
        shadow_buf[i] = shadow_buf[i] + w;
      end
      else
        exp_ncmd = 0;
      if (exp_ncmd != 0 && a >= ERR_BASE)
        r.err = 1'b1;
    end
    // Unsupported ops answer with err only
    if (exp_ncmd == 0)
      r.err = 1'b1;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////
  always @(posedge nice_clk)
  begin
    if (nice_rst_n && icb_cmd_valid && icb_cmd_ready)
      cmd_log.push_back(icb_cmd);
    // Memory responses are never refused
    if (nice_rst_n && icb_rsp_valid)
      check("icb_rsp_ready", 64'(icb_rsp_ready), 64'd1);
  end

  // Compare process that also watches a stalled response
  always @(posedge nice_clk)
  begin : compare
    bit                  held_valid;
    nice_pkg::nice_rsp_t held_rsp;
    if (!nice_rst_n)
      held_valid = 1'b0;
    else if (rsp_valid)
    begin
      if (held_valid)
        check("rsp_hold", 64'(rsp), 64'(held_rsp));
      if (rsp_ready && exp_q.size() == 0)
      begin
        errors++;
        $display("A response came with no request waiting for it");
      end
      else if (rsp_ready)
        check("rsp", 64'(rsp), 64'(exp_q.pop_front()));
      held_valid = !rsp_ready;
      held_rsp = rsp;
    end
    else if (held_valid)
    begin
      errors++;
      held_valid = 1'b0;
      $display("The response was withdrawn before the core took it");
    end
  end

  //////////////////////////////////////////////////
  // One request from start to response handshake
  //////////////////////////////////////////////////
  task automatic issue(input nice_pkg::xlen_t inst, input nice_pkg::addr_t rs1);
    nice_pkg::nice_req_t r;
    int                  cyc;
    int                  first;
    bit                  hs;
    logic [31:0]         rb;
    if (abort)
      return;
    cmd_log.delete();
    r.inst = inst;
    r.rs1 = rs1;
    @(posedge nice_clk);
    req_valid <= 1'b1;
    req <= r;
    cyc = 0;
    hs = 0;
    while (!hs && !abort)
    begin
      @(posedge nice_clk);
      cyc++;
      // A waiting request counts as activity
      check("active", 64'(active), 64'd1);
      if (req_valid && req_ready)
      begin
        hs = 1;
        // Idle right up to acceptance
        check("busy", 64'(busy), 64'd0);
        exp_q.push_back(ref_op(inst, rs1));
        req_valid <= 1'b0;
        rb = stall ? rand_bits(1) : 32'd1;
        rsp_ready <= rb[0];
      end
      else if (cyc > TIMEOUT)
      begin
        errors++;
        abort = 1;
        $display("Timed out waiting for the request to be accepted");
      end
    end
    cyc = 0;
    first = 0;
    hs = 0;
    while (!hs && !abort)
    begin
      @(posedge nice_clk);
      cyc++;
      check("busy", 64'(busy), 64'd1);
      check("active", 64'(active), 64'd1);
      if (rsp_valid && first == 0)
        first = cyc;
      if (rsp_valid && rsp_ready)
        hs = 1;
      else if (cyc > TIMEOUT)
      begin
        errors++;
        abort = 1;
        $display("Timed out waiting for the response handshake");
      end
      else
      begin
        rb = stall ? rand_bits(1) : 32'd1;
        rsp_ready <= rb[0];
      end
    end
    rsp_ready <= 1'b1;
    if (abort)
      return;
    // Unsupported ops answer one cycle after acceptance
    if (exp_ncmd == 0)
      check("rsp_latency", 64'(first), 64'd1);
    check("cmd_count", 64'(cmd_log.size()), 64'(exp_ncmd));
    for (int i = 0; i < exp_ncmd && i < cmd_log.size(); i++)
    begin
      check("icb_cmd.addr", 64'(cmd_log[i].addr), 64'(rs1 + nice_pkg::addr_t'(4 * i)));
      check("icb_cmd.read", 64'(cmd_log[i].read), 64'(exp_read));
      check("icb_cmd.size", 64'(cmd_log[i].size), 64'd2);
      if (!exp_read)
        check("icb_cmd.wdata", 64'(cmd_log[i].wdata), 64'(exp_wdata[i]));
    end
  endtask

  task automatic random_op();
    logic [31:0]     sel;
    nice_pkg::addr_t a;
    sel = rand_bits(2);
    a = rand_bits(10) << 2;
    if (sel == 0)
      issue(make_inst(nice_pkg::F7_LBUF, nice_pkg::F3_LBUF, nice_pkg::OPC_CUSTOM3), a);
    else if (sel == 1)
      issue(make_inst(nice_pkg::F7_SBUF, nice_pkg::F3_SBUF, nice_pkg::OPC_CUSTOM3), a);
    else
      issue(make_inst(nice_pkg::F7_ROWSUM, nice_pkg::F3_ROWSUM, nice_pkg::OPC_CUSTOM3), a);
  endtask

  task automatic report_and_finish();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial
  begin : main
    int              cyc;
    nice_pkg::xlen_t lbuf_i;
    nice_pkg::xlen_t sbuf_i;
    nice_pkg::xlen_t sum_i;
    req_valid = 1'b0;
    req = '0;
    rsp_ready = 1'b1;
    lfsr = 32'h0a48f528;
    errors = 0;
    checks = 0;
    abort = 0;
    stall = 0;
    for (int i = 0; i < nice_pkg::ROWBUF_DP; i++)
      shadow_buf[i] = '0;
    lbuf_i = make_inst(nice_pkg::F7_LBUF, nice_pkg::F3_LBUF, nice_pkg::OPC_CUSTOM3);
    sbuf_i = make_inst(nice_pkg::F7_SBUF, nice_pkg::F3_SBUF, nice_pkg::OPC_CUSTOM3);
    sum_i = make_inst(nice_pkg::F7_ROWSUM, nice_pkg::F3_ROWSUM, nice_pkg::OPC_CUSTOM3);

    cyc = 0;
    while (!nice_rst_n && !abort)
    begin
      @(posedge nice_clk);
      cyc++;
      if (cyc > TIMEOUT)
      begin
        errors++;
        abort = 1;
        $display("Reset never released");
      end
    end

    // Idle outputs once reset is released
    check("rsp_valid", 64'(rsp_valid), 64'd0);
    check("icb_cmd_valid", 64'(icb_cmd_valid), 64'd0);
    check("busy", 64'(busy), 64'd0);
    check("active", 64'(active), 64'd0);
    check("req_ready", 64'(req_ready), 64'd1);
    check("icb_rsp_ready", 64'(icb_rsp_ready), 64'd1);

    // Row copy
    issue(lbuf_i, 32'h0000_0100);
    issue(sbuf_i, 32'h0000_0400);
    // Rowsum over random words
    issue(sum_i, rand_bits(10) << 2);
    // Load, accumulate, store
    issue(lbuf_i, 32'h0000_0200);
    issue(sum_i, 32'h0000_0300);
    issue(sbuf_i, 32'h0000_0500);
    // Error region with one row crossing into it
    issue(lbuf_i, 32'h0000_eff8);
    issue(sbuf_i, 32'h0000_f000);
    issue(sum_i, 32'h0000_f100);
    // Unsupported encodings
    issue(make_inst(7'b0000000, 3'b000, 7'b0110011), 32'h0000_0100);
    issue(make_inst(7'b0000111, nice_pkg::F3_LBUF, nice_pkg::OPC_CUSTOM3), 32'h0000_0100);
    // Random mix with the core stalling responses
    stall = 1;
    for (int i = 0; i < 16; i++)
      random_op();
    stall = 0;
    repeat (4) @(posedge nice_clk);
    report_and_finish();
  end

endmodule

// ==== all.f ====
hw/nice_pkg.sv
hw/nice_ctrl.sv
hw/nice_lsu.sv
hw/nice_row_buf.sv
hw/nice_rowsum_unit.sv
hw/nice_core_top.sv
tests/tb_clk_gen.sv
tests/tb_mem_model.sv
tests/tb_nice_core.sv

// ==== Makefile ====
TOP = tb_nice_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
